/* elink_cfg.f */
source/ecfg_pkg.sv
source/ecfg_if.sv
source/ecfg_regfile.sv
source/ecfg_mailbox.sv
source/ecfg_readback.sv
source/elink_cfg.sv
verif/elink_cfg_tb.sv

/* Bender.yml */
package:
  name: elink_cfg

sources:
  # Shared types first, then the blocks, then the top level
  - source/ecfg_pkg.sv
  - source/ecfg_if.sv
  - source/ecfg_regfile.sv
  - source/ecfg_mailbox.sv
  - source/ecfg_readback.sv
  - source/elink_cfg.sv
  - target: test
    files:
      - verif/elink_cfg_tb.sv

/* verif/elink_cfg_tb.sv */
// Testbench for elink_cfg with a reference model of registers and mailbox
// Checks run only when assertions are enabled in the simulator
`timescale 1ns/100ps
`default_nettype none

module elink_cfg_tb;

   import ecfg_pkg::*;

   localparam logic [11:0] CHIP_ID = 12'h800;
   localparam int TX_REGS = 4;
   localparam int RX_REGS = 4;
   localparam int BASE_REGS = 8;
   localparam int MBOX_DEPTH = 4;
   localparam int RESET_CYCLES = 10;
   // Planned transactions bound the watchdog
   localparam int N_TXN = 260;

   logic sys_clk;
   logic reset;
   logic txwr_access;
   logic txrd_access;
   logic rxwr_access;
   logic rr_wait;
   logic txwr_wait;
   logic txrd_wait;
   logic rr_access;
   emesh_packet_t txwr_packet;
   emesh_packet_t txrd_packet;
   emesh_packet_t rxwr_packet;
   emesh_packet_t rr_packet;

   // Reference model state
   logic [31:0] tx_m [TX_REGS];
   logic [31:0] rx_m [RX_REGS];
   logic [31:0] base_m [BASE_REGS];
   logic [63:0] mbox_q [$];
   logic mbox_ovf;
   emesh_packet_t exp_q [$];
   emesh_packet_t prev_pkt;
   logic prev_hold;
   logic m_txwr;
   logic m_txrd;
   logic m_rxwr;
   logic exp_rdw;
   int errors = 0;
   int n_reads = 0;
   int n_resps = 0;
   int rnd;
   bit bp_on = 1'b0;

   elink_cfg #(
      .CHIP_ID    (CHIP_ID),
      .TX_REGS    (TX_REGS),
      .RX_REGS    (RX_REGS),
      .BASE_REGS  (BASE_REGS),
      .MBOX_DEPTH (MBOX_DEPTH)
   ) u_elink_cfg (
      .sys_clk     (sys_clk),
      .reset       (reset),
      .txwr_access (txwr_access),
      .txwr_packet (txwr_packet),
      .txwr_wait   (txwr_wait),
      .txrd_access (txrd_access),
      .txrd_packet (txrd_packet),
      .txrd_wait   (txrd_wait),
      .rxwr_access (rxwr_access),
      .rxwr_packet (rxwr_packet),
      .rr_access   (rr_access),
      .rr_packet   (rr_packet),
      .rr_wait     (rr_wait)
   );

   initial begin
      sys_clk = 1'b0;
      forever #4 sys_clk = ~sys_clk;
   end

   task automatic report_mismatch(input string name, input logic [103:0] got,
                                  input logic [103:0] exp);
      errors++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
   endtask

   function automatic logic [31:0] reg_addr(input logic [11:0] id, input logic [3:0] grp,
                                            input logic [1:0] blk, input logic [3:0] idx);
      return {id, grp, 8'h00, blk, idx, 2'b00};
   endfunction

   // Block kinds 0 to 3 are mapped and kind 4 hits an unmapped group
   function automatic logic [31:0] random_addr(input bit regs_only);
      int kind;
      logic [3:0] idx;
      logic [31:0] a;
      kind = regs_only ? $urandom % 3 : $urandom % 5;
      idx = 4'($urandom);
      case (kind)
         0: a = reg_addr(CHIP_ID, cfg_group_tx, cfg_block_cfg, idx);
         1: a = reg_addr(CHIP_ID, cfg_group_tx, cfg_block_base, idx);
         2: a = reg_addr(CHIP_ID, cfg_group_rx, cfg_block_cfg, idx);
         3: a = reg_addr(CHIP_ID, cfg_group_rx, cfg_block_base, idx);
         default: a = reg_addr(CHIP_ID, 4'h3, 2'd0, idx);
      endcase
      return a;
   endfunction

   function automatic emesh_packet_t make_pkt(input logic wr, input logic [31:0] dst,
                                              input logic [31:0] data, input logic [31:0] src);
      emesh_packet_t p;
      p.write = wr;
      p.datamode = 2'($urandom);
      p.ctrlmode = 5'($urandom);
      p.dstaddr = dst;
      p.data = data;
      p.srcaddr = src;
      return p;
   endfunction

   // Model write by the decode table
   function automatic void model_write(input logic [31:0] dst, input logic [63:0] din);
      logic [3:0] grp;
      logic [1:0] blk;
      logic [3:0] idx;
      grp = dst[19:16];
      blk = dst[7:6];
      idx = dst[5:2];
      if (grp == cfg_group_tx && blk == 2'd0 && idx < TX_REGS) begin
         tx_m[idx] = din[31:0];
      end else if (grp == cfg_group_tx && blk == 2'd1 && idx < BASE_REGS) begin
         base_m[idx] = din[31:0];
      end else if (grp == cfg_group_rx && blk == 2'd0 && idx < RX_REGS) begin
         rx_m[idx] = din[31:0];
      end else if (grp == cfg_group_rx && blk == 2'd1) begin
         // Full mailbox drops and flags
         if (mbox_q.size() < MBOX_DEPTH) begin
            mbox_q.push_back(din);
         end else begin
            mbox_ovf = 1'b1;
         end
      end
   endfunction

   // Model read pops the mailbox on the high word
   function automatic logic [31:0] model_read(input logic [31:0] dst);
      logic [3:0] grp;
      logic [1:0] blk;
      logic [3:0] idx;
      logic [31:0] v;
      logic [63:0] msg;
      grp = dst[19:16];
      blk = dst[7:6];
      idx = dst[5:2];
      v = '0;
      if (grp == cfg_group_tx && blk == 2'd0 && idx < TX_REGS) begin
         v = tx_m[idx];
      end else if (grp == cfg_group_tx && blk == 2'd1 && idx < BASE_REGS) begin
         v = base_m[idx];
      end else if (grp == cfg_group_rx && blk == 2'd0 && idx < RX_REGS) begin
         v = rx_m[idx];
      end else if (grp == cfg_group_rx && blk == 2'd1) begin
         if (idx == 4'd0 && mbox_q.size() != 0) v = mbox_q[0][31:0];
         if (idx == 4'd1 && mbox_q.size() != 0) begin
            msg = mbox_q.pop_front();
            v = msg[63:32];
         end
         if (idx == 4'd2) v = {mbox_ovf, 31'(mbox_q.size())};
      end
      return v;
   endfunction

   function automatic emesh_packet_t response_for(input emesh_packet_t rd,
                                                  input logic [31:0] value);
      emesh_packet_t r;
      r.write = 1'b1;
      r.datamode = rd.datamode;
      r.ctrlmode = rd.ctrlmode;
      r.dstaddr = rd.srcaddr;
      r.data = value;
      r.srcaddr = rd.dstaddr;
      return r;
   endfunction

   // Monitor samples pre-edge values
   always @(posedge sys_clk) begin
      if (reset) begin
         for (int i = 0; i < TX_REGS; i++) tx_m[i] = '0;
         for (int i = 0; i < RX_REGS; i++) rx_m[i] = '0;
         for (int i = 0; i < BASE_REGS; i++) base_m[i] = '0;
         mbox_q.delete();
         exp_q.delete();
         mbox_ovf = 1'b0;
         prev_hold = 1'b0;
      end else begin
         m_txwr = txwr_access && (txwr_packet.dstaddr[31:20] == CHIP_ID);
         m_txrd = txrd_access && (txrd_packet.dstaddr[31:20] == CHIP_ID);
         m_rxwr = rxwr_access && (rxwr_packet.dstaddr[31:20] == CHIP_ID);
         exp_rdw = (m_txrd && (m_txwr || m_rxwr)) || (rr_access && rr_wait);
         assert (txwr_wait === (m_txwr && m_rxwr))
            else report_mismatch("txwr_wait", txwr_wait, m_txwr && m_rxwr);
         assert (txrd_wait === exp_rdw) else report_mismatch("txrd_wait", txrd_wait, exp_rdw);
         assert (rr_access === (exp_q.size() != 0))
            else report_mismatch("rr_access", rr_access, exp_q.size() != 0);
         if (prev_hold) begin
            assert (rr_packet === prev_pkt) else report_mismatch("rr_packet", rr_packet, prev_pkt);
         end
         // Response taken at this edge, counted from the port itself
         if (rr_access && !rr_wait) begin
            n_resps++;
            if (exp_q.size() != 0) begin
               assert (rr_packet === exp_q[0])
                  else report_mismatch("rr_packet", rr_packet, exp_q[0]);
               void'(exp_q.pop_front());
            end
         end
         // Receive write wins over transmit write
         if (m_rxwr) model_write(rxwr_packet.dstaddr, {rxwr_packet.srcaddr, rxwr_packet.data});
         else if (m_txwr) model_write(txwr_packet.dstaddr, {txwr_packet.srcaddr, txwr_packet.data});
         if (m_txrd && !exp_rdw) begin
            n_reads++;
            exp_q.push_back(response_for(txrd_packet, model_read(txrd_packet.dstaddr)));
         end
         prev_hold = rr_access && rr_wait;
         prev_pkt = rr_packet;
      end
   end

   // A held response blocks further reads
   stall_blocks_read: assert property (@(posedge sys_clk) disable iff (reset)
      (rr_access && rr_wait) |-> txrd_wait)
      else begin
         errors++;
         $display("CHECK FAILED txrd_wait 0x%0h expected 0x1 under stall", $sampled(txrd_wait));
      end

   task automatic send_txwr(input logic [31:0] dst, input logic [31:0] data);
      @(negedge sys_clk);
      txwr_access = 1'b1;
      txwr_packet = make_pkt(1'b1, dst, data, $urandom);
      @(posedge sys_clk);
      while (txwr_wait) @(posedge sys_clk);
      @(negedge sys_clk);
      txwr_access = 1'b0;
   endtask

   task automatic send_rxwr(input logic [31:0] dst, input logic [31:0] data,
                            input logic [31:0] src);
      @(negedge sys_clk);
      rxwr_access = 1'b1;
      rxwr_packet = make_pkt(1'b1, dst, data, src);
      @(posedge sys_clk);
      @(negedge sys_clk);
      rxwr_access = 1'b0;
   endtask

   task automatic send_txrd(input logic [31:0] dst);
      @(negedge sys_clk);
      txrd_access = 1'b1;
      txrd_packet = make_pkt(1'b0, dst, 32'h0, {12'h3a5, 20'($urandom)});
      @(posedge sys_clk);
      while (txrd_wait) @(posedge sys_clk);
      @(negedge sys_clk);
      txrd_access = 1'b0;
   endtask

   // Random write through either write port
   task automatic send_any_write(input logic [31:0] dst);
      if ($urandom % 2) send_rxwr(dst, $urandom, $urandom);
      else send_txwr(dst, $urandom);
   endtask

   // Reads every index of the three register blocks
   task automatic read_all_regs();
      for (int i = 0; i < 16; i++) begin
         send_txrd(reg_addr(CHIP_ID, cfg_group_tx, cfg_block_cfg, 4'(i)));
         send_txrd(reg_addr(CHIP_ID, cfg_group_tx, cfg_block_base, 4'(i)));
         send_txrd(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_cfg, 4'(i)));
      end
   endtask

   // Back-pressure on the readback port
   initial begin
      rr_wait = 1'b0;
      forever begin
         @(negedge sys_clk);
         rr_wait = bp_on ? ($urandom % 3 != 0) : 1'b0;
      end
   end

   initial begin
      repeat (RESET_CYCLES + N_TXN * 20) @(posedge sys_clk);
      $display("Watchdog expired before the tests finished, errors %0d", errors);
      $display("tests failed");
      $finish;
   end

   initial begin
      rnd = $urandom(18);
      reset = 1'b1;
      txwr_access = 1'b0;
      txrd_access = 1'b0;
      rxwr_access = 1'b0;
      txwr_packet = '0;
      txrd_packet = '0;
      rxwr_packet = '0;
      repeat (RESET_CYCLES) @(posedge sys_clk);
      @(negedge sys_clk);
      reset = 1'b0;
      // Registers and an unmapped group read zero after reset
      read_all_regs();
      send_txrd(reg_addr(CHIP_ID, 4'h3, 2'd0, 4'd0));
      // Register round trip
      repeat (32) send_any_write(random_addr(1'b1));
      read_all_regs();
      // Foreign ID is ignored
      send_txwr(reg_addr(12'h801, cfg_group_tx, cfg_block_cfg, 4'd0), 32'hdead_0001);
      send_rxwr(reg_addr(12'h801, cfg_group_rx, cfg_block_cfg, 4'd0), 32'hdead_0002, 32'h0);
      send_txrd(reg_addr(12'h801, cfg_group_tx, cfg_block_cfg, 4'd0));
      send_txrd(reg_addr(CHIP_ID, cfg_group_tx, cfg_block_cfg, 4'd0));
      send_txrd(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_cfg, 4'd0));
      // All three ports at once on the same register
      fork
         send_rxwr(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_cfg, 4'd1), 32'haaaa_0001, 32'h0);
         send_txwr(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_cfg, 4'd1), 32'hbbbb_0002);
         send_txrd(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_cfg, 4'd1));
      join
      fork
         send_txwr(reg_addr(CHIP_ID, cfg_group_tx, cfg_block_base, 4'd2), 32'hcccc_0003);
         send_txrd(reg_addr(CHIP_ID, cfg_group_tx, cfg_block_base, 4'd2));
      join
      // Mailbox order, count and overflow
      for (int i = 0; i < 3; i++) begin
         send_rxwr(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_base, 4'd0), $urandom, $urandom);
      end
      send_txrd(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_base, mbox_stat));
      for (int i = 0; i < 3; i++) begin
         send_txrd(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_base, mbox_lo));
         send_txrd(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_base, mbox_hi));
      end
      send_txrd(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_base, mbox_stat));
      for (int i = 0; i < MBOX_DEPTH + 2; i++) begin
         send_rxwr(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_base, 4'd0), $urandom, $urandom);
      end
      send_txrd(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_base, mbox_stat));
      for (int i = 0; i < MBOX_DEPTH + 1; i++) begin
         send_txrd(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_base, mbox_lo));
         send_txrd(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_base, mbox_hi));
      end
      send_txrd(reg_addr(CHIP_ID, cfg_group_rx, cfg_block_base, mbox_stat));
      // Random traffic under back-pressure
      bp_on = 1'b1;
      fork
         repeat (40) send_txrd(random_addr(1'b0));
         repeat (40) send_any_write(random_addr(1'b0));
      join
      bp_on = 1'b0;
      while (exp_q.size() != 0) @(posedge sys_clk);
      repeat (4) @(posedge sys_clk);
      assert (n_reads == n_resps) else report_mismatch("response count", n_resps, n_reads);
      $display("Errors %0d, reads %0d, responses %0d", errors, n_reads, n_resps);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* source/elink_cfg.sv */
// Config slave top level, all blocks on sys_clk
// Packets not addressed to CHIP_ID are ignored, 64-bit config writes are not supported
`timescale 1ns/100ps
`default_nettype none

module elink_cfg #(
   parameter logic [11:0] CHIP_ID    = 12'h800,
   parameter int          TX_REGS    = 4,
   parameter int          RX_REGS    = 4,
   parameter int          BASE_REGS  = 8,
   parameter int          MBOX_DEPTH = 4
) (
   input  wire                     sys_clk,
   input  wire                     reset,
   // Transmit write
   input  wire                     txwr_access,
   input  ecfg_pkg::emesh_packet_t txwr_packet,
   output logic                    txwr_wait,
   // Transmit read
   input  wire                     txrd_access,
   input  ecfg_pkg::emesh_packet_t txrd_packet,
   output logic                    txrd_wait,
   // Receive write, no wait
   input  wire                     rxwr_access,
   input  ecfg_pkg::emesh_packet_t rxwr_packet,
   // Read responses
   output logic                    rr_access,
   output ecfg_pkg::emesh_packet_t rr_packet,
   input  wire                     rr_wait
);

   import ecfg_pkg::*;

   mi_req_t     mi_req;
   logic        rr_stall;
   logic [31:0] tx_dout;
   logic [31:0] rx_dout;
   logic [31:0] base_dout;
   logic [31:0] mbox_dout;

   // Filter, arbitrate and decode
   ecfg_if #(
      .CHIP_ID (CHIP_ID)
   ) u_if (
      .txwr_access (txwr_access),
      .txwr_packet (txwr_packet),
      .txwr_wait   (txwr_wait),
      .txrd_access (txrd_access),
      .txrd_packet (txrd_packet),
      .txrd_wait   (txrd_wait),
      .rxwr_access (rxwr_access),
      .rxwr_packet (rxwr_packet),
      .rr_stall    (rr_stall),
      .mi_req      (mi_req)
   );

   // Config register banks, low data word only
   ecfg_regfile #(
      .NUM_REGS (TX_REGS)
   ) u_tx_cfg (
      .sys_clk (sys_clk),
      .reset   (reset),
      .en      (mi_req.sel[sel_tx_cfg]),
      .we      (mi_req.we),
      .index   (mi_req.addr[5:2]),
      .wdata   (mi_req.din[31:0]),
      .rdata   (tx_dout)
   );

   ecfg_regfile #(
      .NUM_REGS (RX_REGS)
   ) u_rx_cfg (
      .sys_clk (sys_clk),
      .reset   (reset),
      .en      (mi_req.sel[sel_rx_cfg]),
      .we      (mi_req.we),
      .index   (mi_req.addr[5:2]),
      .wdata   (mi_req.din[31:0]),
      .rdata   (rx_dout)
   );

   ecfg_regfile #(
      .NUM_REGS (BASE_REGS)
   ) u_base_cfg (
      .sys_clk (sys_clk),
      .reset   (reset),
      .en      (mi_req.sel[sel_base_cfg]),
      .we      (mi_req.we),
      .index   (mi_req.addr[5:2]),
      .wdata   (mi_req.din[31:0]),
      .rdata   (base_dout)
   );

   // Mailbox takes the full 64-bit word
   ecfg_mailbox #(
      .DEPTH (MBOX_DEPTH)
   ) u_mailbox (
      .sys_clk (sys_clk),
      .reset   (reset),
      .en      (mi_req.sel[sel_mailbox]),
      .we      (mi_req.we),
      .index   (mi_req.addr[5:2]),
      .wdata   (mi_req.din),
      .rdata   (mbox_dout)
   );

   // Response path
   ecfg_readback u_readback (
      .sys_clk   (sys_clk),
      .reset     (reset),
      .mi_req    (mi_req),
      .tx_dout   (tx_dout),
      .rx_dout   (rx_dout),
      .base_dout (base_dout),
      .mbox_dout (mbox_dout),
      .rr_wait   (rr_wait),
      .rr_access (rr_access),
      .rr_packet (rr_packet),
      .rr_stall  (rr_stall)
   );

endmodule

`default_nettype wire

/* source/ecfg_readback.sv */
// Read data mux and registered response packet
// Response holds while rr_wait is high; the front end blocks reads meanwhile
`timescale 1ns/100ps
`default_nettype none

module ecfg_readback (
   input  wire                     sys_clk,
   input  wire                     reset,
   input  ecfg_pkg::mi_req_t       mi_req,
   input  wire [31:0]              tx_dout,
   input  wire [31:0]              rx_dout,
   input  wire [31:0]              base_dout,
   input  wire [31:0]              mbox_dout,
   input  wire                     rr_wait,
   output logic                    rr_access,
   output ecfg_pkg::emesh_packet_t rr_packet,
   output logic                    rr_stall
);

   import ecfg_pkg::*;

   logic        rd_acc;
   logic [31:0] rd_data;

   // Accepted read this cycle
   assign rd_acc = mi_req.en & ~mi_req.we;

   // One-hot select, unmapped gives zero
   assign rd_data = ({32{mi_req.sel[sel_tx_cfg]}}   & tx_dout)   |
                    ({32{mi_req.sel[sel_rx_cfg]}}   & rx_dout)   |
                    ({32{mi_req.sel[sel_base_cfg]}} & base_dout) |
                    ({32{mi_req.sel[sel_mailbox]}}  & mbox_dout);

   // Response valid
   // New read wins over the take of the old one, so back to back works
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         rr_access <= 1'b0;
      end else if (rd_acc) begin
         rr_access <= 1'b1;
      end else if (rr_access && !rr_wait) begin
         rr_access <= 1'b0;
      end
   end

   // Response payload
   // Source and destination swap for the return trip
   always_ff @(posedge sys_clk) begin
      if (rd_acc) begin
         rr_packet.write    <= 1'b1;
         rr_packet.datamode <= mi_req.rd_datamode;
         rr_packet.ctrlmode <= mi_req.rd_ctrlmode;
         rr_packet.dstaddr  <= mi_req.rd_srcaddr;
         rr_packet.data     <= rd_data;
         rr_packet.srcaddr  <= mi_req.rd_dstaddr;
      end
   end

   // Held response, stops further reads upstream
   assign rr_stall = rr_access & rr_wait;

endmodule

`default_nettype wire

/* source/ecfg_mailbox.sv */
// FIFO of 64-bit messages, any write to the block pushes srcaddr:data
// Pop happens on a read of mbox_hi; a push when full is lost and flagged
`timescale 1ns/100ps
`default_nettype none

module ecfg_mailbox #(
   parameter int DEPTH = 4
) (
   input  wire        sys_clk,
   input  wire        reset,
   input  wire        en,
   input  wire        we,
   input  wire [3:0]  index,
   input  wire [63:0] wdata,
   output logic [31:0] rdata
);

   import ecfg_pkg::*;

   // Pointer and count widths
   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   logic [63:0]   mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          overflow;
   logic          empty;
   logic          full;
   logic          push;
   logic          pop;
   logic [63:0]   head;
   logic [31:0]   stat_word;

   assign empty = (count == '0);
   assign full  = (count == CW'(DEPTH));

   assign push = en & we;
   assign pop  = en & ~we & (index == mbox_hi) & ~empty;

   // Message storage
   always_ff @(posedge sys_clk) begin
      if (push && !full) begin
         mem[wr_ptr] <= wdata;
      end
   end

   // Pointers, fill count and sticky overflow
   // Push and pop never share a cycle
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else if (push) begin
         if (full) begin
            overflow <= 1'b1;
         end else begin
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            count  <= count + 1'b1;
         end
      end else if (pop) begin
         rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count  <= count - 1'b1;
      end
   end

   // Head message, zero when empty
   assign head = empty ? 64'd0 : mem[rd_ptr];

   // Status: overflow in bit 31, fill count at the bottom
   always_comb begin
      stat_word           = '0;
      stat_word[CW-1:0]   = count;
      stat_word[31]       = overflow;
   end

   always_comb begin
      case (index)
         mbox_lo:   rdata = head[31:0];
         mbox_hi:   rdata = head[63:32];
         mbox_stat: rdata = stat_word;
         default:   rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

/* source/ecfg_regfile.sv */
// Bank of 32-bit config registers, combinational read
// Indices at or beyond NUM_REGS read zero and drop writes
`timescale 1ns/100ps
`default_nettype none

module ecfg_regfile #(
   parameter int NUM_REGS = 4
) (
   input  wire        sys_clk,
   input  wire        reset,
   input  wire        en,
   input  wire        we,
   input  wire [3:0]  index,
   input  wire [31:0] wdata,
   output logic [31:0] rdata
);

   // Index bits needed to address the array
   localparam int IW = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

   logic [31:0]   regs [NUM_REGS];
   logic          hit;
   logic [IW-1:0] idx;

   // Index within the implemented range
   assign hit = (index < NUM_REGS);
   assign idx = index[IW-1:0];

   // Register write, cleared by reset
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         regs <= '{default: '0};
      end else if (en && we && hit) begin
         regs[idx] <= wdata;
      end
   end

   // Read port
   // Out of range gives zero
   always_comb begin
      if (hit) begin
         rdata = regs[idx];
      end else begin
         rdata = '0;
      end
   end

endmodule

`default_nettype wire

/* source/ecfg_if.sv */
// Packet front end: ID filter, fixed priority rx write > tx write > tx read
// Purely combinational, senders must hold packets while their wait is high
// Unmapped accesses still complete with an all-zero select
`timescale 1ns/100ps
`default_nettype none

module ecfg_if #(
   parameter logic [11:0] CHIP_ID = 12'h800
) (
   input  wire                     txwr_access,
   input  ecfg_pkg::emesh_packet_t txwr_packet,
   output logic                    txwr_wait,
   input  wire                     txrd_access,
   input  ecfg_pkg::emesh_packet_t txrd_packet,
   output logic                    txrd_wait,
   input  wire                     rxwr_access,
   input  ecfg_pkg::emesh_packet_t rxwr_packet,
   input  wire                     rr_stall,
   output ecfg_pkg::mi_req_t       mi_req
);

   import ecfg_pkg::*;

   // Matched requests per port
   logic        tx_wr;
   logic        tx_rd;
   logic        rx_wr;
   logic        wr_any;
   // Read actually granted this cycle
   logic        rd_go;
   logic        acc;
   logic [19:0] addr;
   logic [63:0] din;
   logic [3:0]  group;
   logic [1:0]  block;
   logic [3:0]  sel;

   // Destination ID is the top 12 address bits
   assign tx_wr = txwr_access & (txwr_packet.dstaddr[31:20] == CHIP_ID);
   assign tx_rd = txrd_access & (txrd_packet.dstaddr[31:20] == CHIP_ID);
   assign rx_wr = rxwr_access & (rxwr_packet.dstaddr[31:20] == CHIP_ID);

   assign wr_any = tx_wr | rx_wr;

   // Read yields to any write and to a held response
   assign rd_go = tx_rd & ~wr_any & ~rr_stall;
   assign acc   = wr_any | rd_go;

   // Rx write never waits
   assign txwr_wait = tx_wr & rx_wr;
   assign txrd_wait = (tx_rd & wr_any) | rr_stall;

   // Address from the winner
   assign addr = rx_wr ? rxwr_packet.dstaddr[19:0] :
                 tx_wr ? txwr_packet.dstaddr[19:0] :
                         txrd_packet.dstaddr[19:0];

   // Write data, srcaddr carries the upper word
   assign din = rx_wr ? {rxwr_packet.srcaddr, rxwr_packet.data} :
                        {txwr_packet.srcaddr, txwr_packet.data};

   // Block decode, the only place it is done
   assign group = addr[19:16];
   assign block = addr[7:6];

   always_comb begin
      sel = '0;
      if (group == cfg_group_tx && block == cfg_block_cfg) begin
         sel[sel_tx_cfg] = 1'b1;
      end
      if (group == cfg_group_tx && block == cfg_block_base) begin
         sel[sel_base_cfg] = 1'b1;
      end
      if (group == cfg_group_rx && block == cfg_block_cfg) begin
         sel[sel_rx_cfg] = 1'b1;
      end
      if (group == cfg_group_rx && block == cfg_block_base) begin
         sel[sel_mailbox] = 1'b1;
      end
   end

   // Request to all blocks
   always_comb begin
      mi_req.en          = acc;
      mi_req.we          = wr_any;
      mi_req.addr        = addr;
      mi_req.din         = din;
      // No select without an accepted access
      mi_req.sel         = acc ? sel : 4'b0000;
      // Read return info, only meaningful when we is low
      mi_req.rd_srcaddr  = txrd_packet.srcaddr;
      mi_req.rd_dstaddr  = txrd_packet.dstaddr;
      mi_req.rd_datamode = txrd_packet.datamode;
      mi_req.rd_ctrlmode = txrd_packet.ctrlmode;
   end

endmodule

`default_nettype wire

/* source/ecfg_pkg.sv */
// Shared types and address map of the elink configuration slave
// Packet layout follows the emesh order, with write in bit 0 and srcaddr on top
`default_nettype none

package ecfg_pkg;

   // Emesh packet, 104 bits
   // First field is the MSB, so srcaddr sits in bits 103:72
   typedef struct packed {
      logic [31:0] srcaddr;
      logic [31:0] data;
      logic [31:0] dstaddr;
      logic [4:0]  ctrlmode;
      logic [1:0]  datamode;
      logic        write;
   } emesh_packet_t;

   // One register-bus access
   typedef struct packed {
      // Access strobe and direction
      logic        en;
      logic        we;
      // Local address, dstaddr bits 19:0
      logic [19:0] addr;
      // Write data as srcaddr:data
      logic [63:0] din;
      // One-hot block select
      logic [3:0]  sel;
      // Return info of a read
      logic [31:0] rd_srcaddr;
      logic [31:0] rd_dstaddr;
      logic [1:0]  rd_datamode;
      logic [4:0]  rd_ctrlmode;
   } mi_req_t;

   // Group field, address bits 19:16
   localparam logic [3:0] cfg_group_tx = 4'hf;
   localparam logic [3:0] cfg_group_rx = 4'he;

   // Block field, address bits 7:6
   localparam logic [1:0] cfg_block_cfg  = 2'd0;
   localparam logic [1:0] cfg_block_base = 2'd1;

   // Bit positions inside mi_req_t.sel
   localparam int sel_tx_cfg   = 0;
   localparam int sel_rx_cfg   = 1;
   localparam int sel_base_cfg = 2;
   localparam int sel_mailbox  = 3;

   // Mailbox register indices, address bits 5:2
   // Reading mbox_hi also pops the head message
   localparam logic [3:0] mbox_lo   = 4'd0;
   localparam logic [3:0] mbox_hi   = 4'd1;
   localparam logic [3:0] mbox_stat = 4'd2;

endpackage

`default_nettype wire
